/* vlog.f */
+incdir+src
src/rvFrontPkg.sv
src/fetchCtrl.sv
src/opDecoder.sv
src/immGen.sv
src/decodeStage.sv
src/frontEnd.sv
dv/frontEnd_asserts.sv
dv/frontEndTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontEndTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/frontEndTb.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module frontEndTb import rvFrontPkg::*; ();

    localparam int N = 23; // instruction table entries
    localparam int TIMEOUT = 3000;

    logic clk;
    logic arstN;
    logic block;
    logic csrError;
    instrWord datIn;
    logic ack;
    logic err;
    logic cyc;
    logic stb;
    logic we;
    pcWord adr;
    logic decValid;
    pcWord decPc;
    logic [4:0] rd;
    immWord imm;
    logic aluASrc;
    logic [1:0] aluBSrc;
    logic [4:0] alu;
    logic isMulti;
    logic isDiv;
    logic isEx;
    branchKind branch;
    logic memWr;
    logic memRd;
    logic regWr;
    logic [2:0] memOp;
    logic csr;
    logic ecall;
    logic mret;
    logic done;
    logic error;
    logic [11:0] csrAddr;

    // ctls bits regWr memRd memWr aluASrc csr ecall done mret err csrOp busErr
    instrWord words[N];
    immWord imms[N];
    branchKind brs[N];
    aluCtrl alus[N];
    logic [1:0] bsrcs[N];
    logic [10:0] ctls[N];
    logic [2:0] kinds[N]; // isMulti isDiv isEx

    logic [31:0] lfsr = 32'h20e5c6db;
    logic busy = 1'b0;
    int waitLeft = 0;
    pcWord nextAdr = `RESET_PC; // expected address of the next request
    pcWord expPc = `RESET_PC;
    int consumed = 0;
    int errCount = 0;
    bit ok;

    frontEnd frontEnd_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [1:0] drawTwoBits();
        logic [1:0] v;
        for (int k = 0; k < 2; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v[k] = lfsr[0];
        end
        return v;
    endfunction

    function automatic int errorTotal();
        return errCount + frontEnd_i.asserts_i.failCount;
    endfunction

    task automatic setEntry(input int i, input instrWord w, input immWord im,
                            input branchKind br, input aluCtrl a, input logic [1:0] b,
                            input logic [10:0] c);
        words[i] = w;
        imms[i]  = im;
        brs[i]   = br;
        alus[i]  = a;
        bsrcs[i] = b;
        ctls[i]  = c;
    endtask

    task automatic checkField(input pcWord pc, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("ERR %0t pc %h %s is %h, expected %h", $time, pc, name, got, exp);
            errCount++;
        end
    endtask

    // Wishbone slave with random wait states and the block driver
    always @(posedge clk) begin : busModel
        int idx;
        int w;
        if (arstN) begin
            block <= (drawTwoBits() == 2'b11);
            if (ack || err) begin
                ack  <= 1'b0;
                err  <= 1'b0;
                busy <= 1'b0;
            end else if (stb) begin
                idx = int'((adr - `RESET_PC) >> 2) % N;
                w = busy ? waitLeft : int'(drawTwoBits());
                if (!busy) begin
                    assert (adr == nextAdr) else begin
                        $display("ERR %0t request adr %h, expected %h", $time, adr, nextAdr);
                        errCount++;
                    end
                    nextAdr <= nextAdr + 4;
                end
                busy <= 1'b1;
                if (w == 0) begin
                    datIn <= words[idx];
                    ack   <= !ctls[idx][0];
                    err   <= ctls[idx][0];
                end else begin
                    waitLeft <= w - 1;
                end
            end
        end
    end

    // a word is taken by execute on an edge with decValid high and block low
    always @(posedge clk) begin : decodeCheck
        int i;
        logic errE;
        if (arstN && decValid && !block) begin
            i = int'((expPc - `RESET_PC) >> 2) % N;
            errE = ctls[i][2] || ctls[i][0] || (ctls[i][1] && csrError);
            checkField(decPc, "pc low word", decPc[31:0], expPc[31:0]);
            checkField(decPc, "pc high word", decPc[63:32], expPc[63:32]);
            checkField(decPc, "imm", imm, imms[i]);
            checkField(decPc, "controls",
                {5'b0, branch, alu, isMulti, isDiv, isEx, aluBSrc, regWr, memRd, memWr,
                 aluASrc, csr, ecall, done, mret, error, rd},
                {5'b0, brs[i], alus[i][4:0], kinds[i], bsrcs[i], ctls[i][10:3], errE,
                 words[i][11:7]});
            checkField(decPc, "memOp csrAddr", {17'b0, memOp, csrAddr},
                {17'b0, words[i][14:12], words[i][31:20]});
            expPc    <= expPc + 4;
            consumed <= consumed + 1;
        end
    end

    task automatic waitWords(input int target, inout bit okFlag);
        int cycles;
        cycles = 0;
        while (okFlag && consumed < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout while waiting for decoded word %0d", target);
                okFlag = 1'b0;
            end
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("test %s: %0d words, %0d errors", name, consumed, errorTotal() - errBefore);
    endtask

    initial begin
        int errBefore;
        arstN = 1'b0;
        block = 1'b0;
        csrError = 1'b0;
        ack = 1'b0;
        err = 1'b0;
        datIn = '0;
        setEntry(0, 32'h123450B7, 32'h12345000, 3'b000, 6'h0F, 2'd2, 11'b10000000000);
        setEntry(1, 32'hFFFFF117, 32'hFFFFF000, 3'b000, 6'h00, 2'd2, 11'b10010000000);
        setEntry(2, 32'h008000EF, 32'h00000008, 3'b001, 6'h00, 2'd1, 11'b10010000000);
        setEntry(3, 32'h00408067, 32'h00000004, 3'b010, 6'h00, 2'd1, 11'b10010000000);
        setEntry(4, 32'hFE208EE3, 32'hFFFFFFFC, 3'b100, 6'h02, 2'd0, 11'b00000000000);
        setEntry(5, 32'h0020E863, 32'h00000010, 3'b110, 6'h03, 2'd0, 11'b00000000000);
        setEntry(6, 32'h0080B183, 32'h00000008, 3'b000, 6'h00, 2'd2, 11'b11000000000);
        setEntry(7, 32'hFE20BC23, 32'hFFFFFFF8, 3'b000, 6'h00, 2'd2, 11'b00100000000);
        setEntry(8, 32'hFFF00293, 32'hFFFFFFFF, 3'b000, 6'h00, 2'd2, 11'b10000000000);
        setEntry(9, 32'h0072831B, 32'h00000007, 3'b000, 6'h10, 2'd2, 11'b10000000000);
        setEntry(10, 32'h002083B3, 32'h00000002, 3'b000, 6'h00, 2'd0, 11'b10000000000);
        setEntry(11, 32'h02208433, 32'h00000022, 3'b000, 6'h20, 2'd0, 11'b10000000000);
        setEntry(12, 32'h0220C4BB, 32'h00000022, 3'b000, 6'h34, 2'd0, 11'b10000000000);
        setEntry(13, 32'h30009573, 32'h00000300, 3'b000, 6'h0F, 2'd3, 11'b10001000010);
        // illegal encodings and the bus error
        setEntry(14, 32'h042083B3, 32'h00000042, 3'b000, 6'h00, 2'd0, 11'b10000000100);
        setEntry(15, 32'h0080F183, 32'h00000008, 3'b000, 6'h00, 2'd2, 11'b11000000100);
        setEntry(16, 32'h00409067, 32'h00000004, 3'b010, 6'h00, 2'd1, 11'b10010000100);
        setEntry(17, 32'hFFF00291, 32'hFFFFFFFF, 3'b000, 6'h00, 2'd2, 11'b10000000100);
        setEntry(18, 32'h00200073, 32'h00000002, 3'b000, 6'h0F, 2'd3, 11'b10001000100);
        setEntry(19, 32'h00000073, 32'h00000000, 3'b000, 6'h0F, 2'd3, 11'b10001100000);
        setEntry(20, 32'h00100073, 32'h00000001, 3'b000, 6'h0F, 2'd3, 11'b10001010000);
        setEntry(21, 32'h30200073, 32'h00000302, 3'b000, 6'h0F, 2'd3, 11'b10001001000);
        setEntry(22, 32'h002083B3, 32'h00000002, 3'b000, 6'h00, 2'd0, 11'b10000000001);
        foreach (kinds[k]) begin
            kinds[k] = 3'b001; // plain integer op
        end
        kinds[11] = 3'b100; // mul
        kinds[12] = 3'b010; // divw
        ok = 1'b1;
        errBefore = errorTotal();
        repeat (16) @(posedge clk);
        assert (!cyc && !stb && !decValid) else begin
            $display("ERR %0t bus or decode active during reset", $time);
            errCount++;
        end
        arstN <= 1'b1;
        reportTest("reset", errBefore);
        errBefore = errorTotal();
        waitWords(N, ok);
        reportTest("decode with csrError low", errBefore);
        if (ok) begin
            errBefore = errorTotal();
            csrError <= 1'b1; // csrrw now has to flag an error
            waitWords(2 * N, ok);
            reportTest("decode with csrError high", errBefore);
        end
        $display("tests 3, words %0d, errors %0d, timeout %0d", consumed, errorTotal(), !ok);
        if (ok && errorTotal() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* dv/frontEnd_asserts.sv */
`timescale 1ns/1ps

module frontEnd_asserts import rvFrontPkg::*; (
    input logic      clk,
    input logic      arstN,
    input logic      block,
    input logic      cyc,
    input logic      stb,
    input logic      we,
    input pcWord     adr,
    input logic      ack,
    input logic      err,
    input logic      decValid,
    input pcWord     decPc,
    input immWord    imm,
    input logic [4:0] alu,
    input branchKind branch
);

    int failCount = 0; // read by the testbench

    resetIdle: assert property (@(posedge clk) !arstN |-> !cyc && !stb && !decValid)
        else begin
            $error("bus or decode active in reset");
            failCount++;
        end

    readOnly: assert property (@(posedge clk) !we)
        else begin
            $error("write strobe on fetch port");
            failCount++;
        end

    // request held with a stable address until terminated
    reqHeld: assert property (@(posedge clk) disable iff (!arstN)
        stb && !ack && !err |=> stb && cyc && $stable(adr))
        else begin
            $error("request dropped or address moved");
            failCount++;
        end

    reqEnds: assert property (@(posedge clk) disable iff (!arstN)
        stb && (ack || err) |=> !stb && !cyc)
        else begin
            $error("request still up after termination");
            failCount++;
        end

    holdStable: assert property (@(posedge clk) disable iff (!arstN)
        block |=> $stable(decValid) && $stable(decPc) && $stable(imm) &&
                  $stable(alu) && $stable(branch))
        else begin
            $error("decode outputs changed under block");
            failCount++;
        end

endmodule

bind frontEnd frontEnd_asserts asserts_i (.*);

/* src/frontEnd.sv */
`timescale 1ns/1ps

module frontEnd import rvFrontPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        block,
    input  logic        csrError,
    input  instrWord    datIn,
    input  logic        ack,
    input  logic        err,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output pcWord       adr,
    output logic        decValid,
    output pcWord       decPc,
    output logic [4:0]  rd,
    output immWord      imm,
    output logic        aluASrc,
    output logic [1:0]  aluBSrc,
    output logic [4:0]  alu,
    output logic        isMulti,
    output logic        isDiv,
    output logic        isEx,
    output branchKind   branch,
    output logic        memWr,
    output logic        memRd,
    output logic        regWr,
    output logic [2:0]  memOp,
    output logic        csr,
    output logic        ecall,
    output logic        mret,
    output logic        done,
    output logic        error,
    output logic [11:0] csrAddr
);

    logic     fetchValid;
    logic     fetchErr;
    instrWord fetchInstr;
    pcWord    fetchPc;

    fetchCtrl fetchCtrl_i (.*); // Wishbone side and fetch handoff

    decodeStage decodeStage_i (.*);

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import rvFrontPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       block,
    input  logic       fetchValid,
    input  logic       fetchErr,
    input  logic       csrError,
    input  instrWord   fetchInstr,
    input  pcWord      fetchPc,
    output logic       decValid,
    output pcWord      decPc,
    output logic [4:0] rd,
    output immWord     imm,
    output logic       aluASrc,
    output logic [1:0] aluBSrc,
    output logic [4:0] alu,
    output logic       isMulti,
    output logic       isDiv,
    output logic       isEx,
    output branchKind  branch,
    output logic       memWr,
    output logic       memRd,
    output logic       regWr,
    output logic [2:0] memOp,
    output logic       csr,
    output logic       ecall,
    output logic       mret,
    output logic       done,
    output logic       error,
    output logic [11:0] csrAddr
);

    instrWord instrQ;
    logic     errQ;
    extKind   ext;
    aluCtrl   aluLine;
    logic     illegal;
    logic     sysBad;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
        end else if (!block) begin
            decValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            decPc  <= fetchPc;
            instrQ <= fetchInstr;
            errQ   <= fetchErr;
        end
    end

    opDecoder opDecoder_i (
        .opcode(instrQ[6:0]), .funct3(instrQ[14:12]), .funct7(instrQ[31:25]),
        .ext(ext), .regWr(regWr), .aluASrc(aluASrc), .memWr(memWr), .memRd(memRd),
        .csr(csr), .illegal(illegal), .aluBSrc(aluBSrc), .alu(aluLine),
        .branch(branch), .memOp(memOp)
    );

    immGen immGen_i (.instrBits(instrQ[31:7]), .ext(ext), .imm(imm));

    assign ecall = (instrQ == 32'h0000_0073);
    assign done  = (instrQ == 32'h0010_0073); // ebreak
    assign mret  = (instrQ == 32'h3020_0073);

    // funct3 000 must be one of the exact words, csr ops need a legal address
    assign sysBad = (instrQ[14:12] == 3'b000) ? !(ecall || done || mret) : csrError;
    assign error  = illegal || errQ || (csr && sysBad);

    assign rd      = instrQ[11:7];
    assign csrAddr = instrQ[31:20];
    assign alu     = aluLine[4:0];
    assign isMulti = aluLine[5] && !aluLine[4];
    assign isDiv   = aluLine[5] && aluLine[4];
    assign isEx    = !aluLine[5];

endmodule

/* src/immGen.sv */
`timescale 1ns/1ps

module immGen import rvFrontPkg::*; (
    input  logic [31:7] instrBits,
    input  extKind      ext,
    output immWord      imm
);

    always_comb begin
        case (ext)
            EXT_S: imm = {{20{instrBits[31]}}, instrBits[31:25], instrBits[11:7]};
            EXT_B: imm = {{19{instrBits[31]}}, instrBits[31], instrBits[7],
                          instrBits[30:25], instrBits[11:8], 1'b0};
            EXT_U: imm = {instrBits[31:12], 12'b0};
            EXT_J: imm = {{11{instrBits[31]}}, instrBits[31], instrBits[19:12],
                          instrBits[20], instrBits[30:21], 1'b0};
            default: imm = {{20{instrBits[31]}}, instrBits[31:20]}; // I format
        endcase
    end

endmodule

/* src/opDecoder.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module opDecoder import rvFrontPkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output extKind     ext,
    output logic       regWr,
    output logic       aluASrc,
    output logic       memWr,
    output logic       memRd,
    output logic       csr,
    output logic       illegal,
    output logic [1:0] aluBSrc,
    output aluCtrl     alu,
    output branchKind  branch,
    output logic [2:0] memOp
);

    logic [4:0] op;
    logic [3:0] aluOp;
    logic       bad;
    logic       mExt;
    logic       wordOp;

    assign op = opcode[6:2];

    always_comb begin
        ext     = EXT_I;
        aluBSrc = 2'd2; // immediate operand by default
        aluOp   = 4'b0000;
        branch  = 3'b000;
        bad     = 1'b0;
        case (op)
            `OP_SYSTEM: begin
                aluBSrc = 2'd3;
                aluOp   = 4'b1111;
                bad     = (funct3 == 3'b100);
            end
            `OP_LUI: begin
                ext   = EXT_U;
                aluOp = 4'b1111; // pass B
            end
            `OP_AUIPC: ext = EXT_U;
            `OP_JAL: begin
                ext     = EXT_J;
                aluBSrc = 2'd1;
                branch  = 3'b001;
            end
            `OP_JALR: begin
                aluBSrc = 2'd1;
                branch  = 3'b010;
                bad     = (funct3 != 3'b000);
            end
            `OP_BRANCH: begin
                ext     = EXT_B;
                aluBSrc = 2'd0;
                if (funct3[2:1] == 2'b01) begin
                    bad = 1'b1;
                end else begin
                    aluOp  = funct3[1] ? 4'b0011 : 4'b0010; // unsigned compare
                    branch = {1'b1, funct3[2], funct3[0]};
                end
            end
            `OP_LOAD: bad = (funct3 == 3'b111);
            `OP_STORE: begin
                ext = EXT_S;
                bad = funct3[2];
            end
            `OP_OPIMM: begin
                aluOp = {funct7[5] && (funct3 == 3'b101), funct3};
                bad   = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000)) ||
                        ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000) &&
                         (funct7[6:1] != 6'b010000));
            end
            `OP_OPIMM32: begin
                aluOp = {funct7[5] && (funct3 == 3'b101), funct3};
                bad   = !((funct3 == 3'b000) ||
                          ((funct3 == 3'b001) && (funct7 == 7'b0000000)) ||
                          ((funct3 == 3'b101) && (funct7 == 7'b0000000 ||
                                                  funct7 == 7'b0100000)));
            end
            `OP_OP: begin
                aluBSrc = 2'd0;
                aluOp   = {funct7[5], funct3};
                bad     = !((funct7 == 7'b0000000) || (funct7 == 7'b0000001) ||
                            ((funct7 == 7'b0100000) && (funct3 == 3'b000 ||
                                                        funct3 == 3'b101)));
            end
            `OP_OP32: begin
                aluBSrc = 2'd0;
                aluOp   = {funct7[5], funct3};
                bad     = !(((funct7 == 7'b0000000) && (funct3 == 3'b000 ||
                             funct3 == 3'b001 || funct3 == 3'b101)) ||
                            ((funct7 == 7'b0100000) && (funct3 == 3'b000 ||
                             funct3 == 3'b101)) ||
                            ((funct7 == 7'b0000001) && (funct3 == 3'b000 ||
                             funct3[2])));
            end
            default: begin
                aluBSrc = 2'd0;
                bad     = 1'b1; // unknown family
            end
        endcase
    end

    assign mExt   = ((op == `OP_OP) || (op == `OP_OP32)) && funct7[0];
    assign wordOp = (op == `OP_OP32) || (op == `OP_OPIMM32);
    assign alu    = {mExt, wordOp, aluOp};

    assign aluASrc = (op == `OP_AUIPC) || (op == `OP_JAL) || (op == `OP_JALR); // pc as A
    assign regWr   = (op != `OP_BRANCH) && (op != `OP_STORE);
    assign memWr   = (op == `OP_STORE);
    assign memRd   = (op == `OP_LOAD);
    assign memOp   = funct3;
    assign csr     = (op == `OP_SYSTEM);
    assign illegal = bad || (opcode[1:0] != 2'b11);

endmodule

/* src/fetchCtrl.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module fetchCtrl import rvFrontPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      block,
    input  instrWord  datIn,
    input  logic      ack,
    input  logic      err,
    output logic      cyc,
    output logic      stb,
    output logic      we,
    output pcWord     adr,
    output logic      fetchValid,
    output logic      fetchErr,
    output instrWord  fetchInstr,
    output pcWord     fetchPc
);

    fetchState state;
    fetchState stateNext;
    pcWord     pc;
    pcWord     holdPc;
    instrWord  holdInstr;
    logic      holdErr;
    logic      xferDone;

    assign xferDone = (state == REQ) && (ack || err); // ack or err ends the cycle

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: stateNext = REQ;
            REQ: begin
                if (xferDone) begin
                    stateNext = block ? HOLD : IDLE;
                end
            end
            HOLD: begin
                if (!block) begin
                    stateNext = IDLE; // buffered word taken by decode
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            pc    <= `RESET_PC;
        end else begin
            state <= stateNext;
            if (xferDone) begin
                pc <= pc + pcWord'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xferDone && block) begin
            holdInstr <= datIn;
            holdPc    <= pc;
            holdErr   <= err;
        end
    end

    assign cyc = (state == REQ);
    assign stb = (state == REQ);
    assign we  = 1'b0; // read only port
    assign adr = pc;

    assign fetchValid = xferDone || (state == HOLD);
    assign fetchInstr = (state == HOLD) ? holdInstr : datIn;
    assign fetchPc    = (state == HOLD) ? holdPc : pc;
    assign fetchErr   = (state == HOLD) ? holdErr : err;

endmodule

/* src/rvFrontPkg.sv */
`include "decode_defs.svh"

package rvFrontPkg;

    typedef logic [31:0] instrWord;
    typedef logic [`XLEN-1:0] pcWord;
    typedef logic [31:0] immWord;

    // [5] M ext, [4] word op, [3:0] operation
    typedef logic [5:0] aluCtrl;

    // 000 none, 001 jal, 010 jalr, 1xx conditional
    typedef logic [2:0] branchKind;

    // immediate formats
    typedef enum logic [2:0] {
        EXT_I,
        EXT_J,
        EXT_S,
        EXT_B,
        EXT_U
    } extKind;

    // Wishbone fetch FSM
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        HOLD
    } fetchState;

endpackage

/* src/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define XLEN 64
`define RESET_PC 64'h8000_0000

// major opcode values, instruction bits 6..2
`define OP_LOAD    5'b00000
`define OP_STORE   5'b01000
`define OP_OPIMM   5'b00100
`define OP_OPIMM32 5'b00110
`define OP_OP      5'b01100
`define OP_OP32    5'b01110
`define OP_LUI     5'b01101
`define OP_AUIPC   5'b00101
`define OP_JAL     5'b11011
`define OP_JALR    5'b11001
`define OP_BRANCH  5'b11000
`define OP_SYSTEM  5'b11100

`endif
